//--- filelist.f
+incdir+sim
source/mult_pkg.sv
source/mult_operand_prep.sv
source/mult_stage.sv
source/mult_pipeline.sv
source/mult_fu.sv
sim/mult_fu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the multiply unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing \
    -f filelist.f \
    --top-module mult_fu_tb \
    -o mult_fu_sim

./obj_dir/mult_fu_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation log clean"
exit 0

//--- sim/mult_model.svh
`ifndef mult_model_svh
`define mult_model_svh

// full 64-bit product, each source extended as the function asks
function automatic logic [63:0] model_product(
    input mult_func_t  func,
    input logic [31:0] a,
    input logic [31:0] b
);
    longint sa;
    longint sb;
    longint ua;
    longint ub;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = longint'({32'd0, a});
    ub = longint'({32'd0, b});
    case (func)
        m_mul, m_mulh: return sa * sb;
        m_mulhsu:      return sa * ub;
        default:       return ua * ub;
    endcase
endfunction

// bus packet the unit should offer for one instruction
function automatic cdb_packet_t model_expect(
    input mult_func_t  func,
    input logic [31:0] a,
    input logic [31:0] b,
    input phys_reg_t   dest,
    input b_mask_t     bm
);
    cdb_packet_t expected;
    logic [63:0] product;
    product = model_product(func, a, b);
    expected.valid  = 1'b1;
    expected.result = (func == m_mul) ? product[31:0] : product[63:32];
    expected.dest   = dest;
    expected.bm     = bm;
    return expected;
endfunction

// a correct prediction only drops the resolved tag
function automatic b_mask_t model_bm(input b_mask_t bm, input b_mask_t resolve);
    return bm & ~resolve;
endfunction

function automatic logic model_killed(
    input b_mask_t bm,
    input b_mask_t resolve,
    input logic    mispred
);
    return mispred && ((bm & resolve) != '0);
endfunction

`endif

//--- sim/mult_fu_tb.sv
module mult_fu_tb import mult_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    `include "mult_model.svh"

    localparam int wait_limit = 100;

    logic         clock;
    logic         reset;
    mult_packet_t mult_packet_in;
    logic         cdb_en;
    b_mask_t      b_mm_resolve;
    logic         b_mm_mispred;
    logic         fu_free;
    logic         cdb_valid;
    cdb_packet_t  mult_result;

    int          cycle = 0;
    integer      seed = 32'h856d8d27;
    int          value_errors = 0;
    int          other_errors = 0;
    int          last_accept_cycle;
    cdb_packet_t expected_q[$];
    cdb_packet_t taken_q[$];
    int          taken_cycle_q[$];

    logic [31:0] corner_a [5] = '{32'hfffffffd, 32'h80000000, 32'h80000000, 32'h0, 32'hffffffff};
    logic [31:0] corner_b [5] = '{32'hfffffff9, 32'h80000000, 32'h7fffffff, 32'h12345678,
                                  32'hffffffff};

    mult_fu dut0 (
        .clock          (clock),
        .reset          (reset),
        .mult_packet_in (mult_packet_in),
        .cdb_en         (cdb_en),
        .b_mm_resolve   (b_mm_resolve),
        .b_mm_mispred   (b_mm_mispred),
        .fu_free        (fu_free),
        .cdb_valid      (cdb_valid),
        .mult_result    (mult_result)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    // record every offer that the bus grant takes on the next rise
    always @(negedge clock) begin
        if (!reset && cdb_valid && cdb_en) begin
            taken_q.push_back(mult_result);
            taken_cycle_q.push_back(cycle);
        end
    end

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    task automatic clear_queues();
        expected_q.delete();
        taken_q.delete();
        taken_cycle_q.delete();
    endtask

    // single issue attempt that holds the packet for one edge
    task automatic try_issue(input mult_func_t func, input logic [31:0] a, input logic [31:0] b,
                             input phys_reg_t dest, input b_mask_t bm, output logic accepted);
        mult_packet_in.valid = 1'b1;
        mult_packet_in.func  = func;
        mult_packet_in.src1  = a;
        mult_packet_in.src2  = b;
        mult_packet_in.dest  = dest;
        mult_packet_in.bm    = bm;
        @(negedge clock);
        accepted = fu_free;
        if (accepted) begin
            last_accept_cycle = cycle;
            expected_q.push_back(model_expect(func, a, b, dest, bm));
        end
        @(posedge clock);
        #1;
        mult_packet_in = '0;
    endtask

    task automatic issue(input mult_func_t func, input logic [31:0] a, input logic [31:0] b,
                         input phys_reg_t dest, input b_mask_t bm);
        int   waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        while (!accepted && waited < wait_limit) begin
            try_issue(func, a, b, dest, bm, accepted);
            waited++;
        end
        assert (accepted) else begin
            other_errors++;
            $display("issue timed out, fu_free stayed low for %0d cycles", wait_limit);
        end
    endtask

    // pulse branch resolution for one cycle and update the expected queue by the same rule
    task automatic apply_resolve(input string name, input b_mask_t resolve,
                                 input logic mispred);
        cdb_packet_t kept[$];
        cdb_packet_t entry;
        logic        front_killed;
        b_mm_resolve = resolve;
        b_mm_mispred = mispred;
        // the oldest entry waits on the bus while the grant is low
        front_killed = expected_q.size() > 0
                       && model_killed(expected_q[0].bm, resolve, mispred);
        foreach (expected_q[i]) begin
            entry = expected_q[i];
            if (!model_killed(entry.bm, resolve, mispred)) begin
                entry.bm = model_bm(entry.bm, resolve);
                kept.push_back(entry);
            end
        end
        expected_q = kept;
        @(negedge clock);
        if (front_killed) begin
            assert (!cdb_valid) else begin
                value_errors++;
                $display("Fail %s offer during resolve: expected cdb_valid 0, actual %b",
                         name, cdb_valid);
            end
        end else if (expected_q.size() > 0) begin
            assert (cdb_valid && mult_result == expected_q[0]) else begin
                value_errors++;
                $display("Fail %s offer during resolve: expected %h, actual %h",
                         name, expected_q[0], mult_result);
            end
        end
        @(posedge clock);
        #1;
        b_mm_resolve = '0;
        b_mm_mispred = 1'b0;
    endtask

    task automatic drain_and_compare(input string name);
        int waited;
        int count;
        waited = 0;
        cdb_en = 1'b1;
        while (taken_q.size() < expected_q.size() && waited < wait_limit) begin
            @(posedge clock);
            waited++;
        end
        assert (taken_q.size() >= expected_q.size()) else begin
            other_errors++;
            $display("%s: only %0d of %0d results arrived before the timeout",
                     name, taken_q.size(), expected_q.size());
        end
        // extra idle cycles so that a stray or repeated offer shows up
        repeat (2 * mult_stages) @(posedge clock);
        #1;
        assert (taken_q.size() == expected_q.size()) else begin
            other_errors++;
            $display("%s: %0d results arrived where %0d were expected",
                     name, taken_q.size(), expected_q.size());
        end
        count = (taken_q.size() < expected_q.size()) ? taken_q.size() : expected_q.size();
        for (int i = 0; i < count; i++) begin
            assert (taken_q[i] == expected_q[i]) else begin
                value_errors++;
                $display("Fail %s result %0d: expected %h, actual %h",
                         name, i, expected_q[i], taken_q[i]);
            end
        end
    endtask

    task automatic reset_state();
        @(negedge clock);
        assert (!cdb_valid) else begin
            value_errors++;
            $display("Fail reset_state cdb_valid: expected 0, actual %b", cdb_valid);
        end
        assert (fu_free) else begin
            value_errors++;
            $display("Fail reset_state fu_free: expected 1, actual %b", fu_free);
        end
        @(posedge clock);
        #1;
    endtask

    task automatic function_mix();
        int idx;
        clear_queues();
        cdb_en = 1'b1;
        idx = 0;
        for (int k = 0; k < 4; k++) begin
            for (int c = 0; c < 5; c++) begin
                issue(mult_func_t'(k[1:0]), corner_a[c], corner_b[c], idx[5:0], idx[3:0]);
                idx++;
            end
            for (int r = 0; r < 3; r++) begin
                issue(mult_func_t'(k[1:0]), random_word(), random_word(), idx[5:0], idx[3:0]);
                idx++;
            end
        end
        drain_and_compare("function_mix");
    endtask

    task automatic streaming();
        int first_accept;
        logic [31:0] word;
        clear_queues();
        cdb_en = 1'b1;
        for (int i = 0; i < 16; i++) begin
            word = random_word();
            issue(mult_func_t'(word[1:0]), random_word(), random_word(), i[5:0], word[7:4]);
            if (i == 0) begin
                first_accept = last_accept_cycle;
            end
        end
        drain_and_compare("streaming");
        if (taken_cycle_q.size() > 0) begin
            assert (taken_cycle_q[0] - first_accept == mult_stages) else begin
                value_errors++;
                $display("Fail streaming latency: expected %0d, actual %0d",
                         mult_stages, taken_cycle_q[0] - first_accept);
            end
        end
        for (int i = 1; i < taken_cycle_q.size(); i++) begin
            assert (taken_cycle_q[i] == taken_cycle_q[i-1] + 1) else begin
                value_errors++;
                $display("Fail streaming spacing %0d: expected 1, actual %0d",
                         i, taken_cycle_q[i] - taken_cycle_q[i-1]);
            end
        end
    endtask

    task automatic backpressure();
        logic accepted;
        int   count;
        clear_queues();
        cdb_en = 1'b0;
        count = 0;
        accepted = 1'b1;
        while (accepted && count < wait_limit) begin
            try_issue(m_mulhsu, random_word(), random_word(), 6'(count + 40), 4'h0, accepted);
            if (accepted) begin
                count++;
            end
        end
        assert (!accepted) else begin
            other_errors++;
            $display("backpressure: fu_free never fell with the bus grant held low");
        end
        assert (count <= mult_stages) else begin
            value_errors++;
            $display("Fail backpressure accepted: expected at most %0d, actual %0d",
                     mult_stages, count);
        end
        repeat (3) @(posedge clock);
        #1;
        assert (!fu_free) else begin
            other_errors++;
            $display("backpressure: fu_free rose while the bus grant was still low");
        end
        drain_and_compare("backpressure");
    endtask

    task automatic mispredict();
        clear_queues();
        cdb_en = 1'b0;
        issue(m_mul, random_word(), random_word(), 6'd10, 4'b0001);
        issue(m_mulh, random_word(), random_word(), 6'd11, 4'b0010);
        issue(m_mulhu, random_word(), random_word(), 6'd12, 4'b0011);
        issue(m_mulhsu, random_word(), random_word(), 6'd13, 4'b0100);
        repeat (2) @(posedge clock);
        #1;
        apply_resolve("mispredict", 4'b0001, 1'b1);
        drain_and_compare("mispredict");
    endtask

    task automatic correct_prediction();
        clear_queues();
        cdb_en = 1'b0;
        issue(m_mulhu, random_word(), random_word(), 6'd20, 4'b0010);
        issue(m_mul, random_word(), random_word(), 6'd21, 4'b0011);
        issue(m_mulh, random_word(), random_word(), 6'd22, 4'b0000);
        issue(m_mulhsu, random_word(), random_word(), 6'd23, 4'b0110);
        repeat (2) @(posedge clock);
        #1;
        apply_resolve("correct_prediction", 4'b0010, 1'b0);
        drain_and_compare("correct_prediction");
    endtask

    initial begin
        reset          = 1'b1;
        mult_packet_in = '0;
        cdb_en         = 1'b0;
        b_mm_resolve   = '0;
        b_mm_mispred   = 1'b0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;

        reset_state();
        function_mix();
        streaming();
        backpressure();
        mispredict();
        correct_prediction();

        $display("summary: value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- source/mult_fu.sv
module mult_fu import mult_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  mult_packet_t mult_packet_in,

    // grant from the bus arbiter
    input  logic         cdb_en,
    input  b_mask_t      b_mm_resolve,
    input  logic         b_mm_mispred,

    output logic         fu_free,
    output logic         cdb_valid,
    output cdb_packet_t  mult_result
);

    mult_stage_packet_t first_packet;
    mult_stage_packet_t final_packet;

    mult_operand_prep u_prep (
        .mult_packet_in (mult_packet_in),
        .b_mm_resolve   (b_mm_resolve),
        .b_mm_mispred   (b_mm_mispred),
        .stage_packet   (first_packet)
    );

    mult_pipeline u_pipeline (
        .clock        (clock),
        .reset        (reset),
        .packet_in    (first_packet),
        .cdb_en       (cdb_en),
        .b_mm_resolve (b_mm_resolve),
        .b_mm_mispred (b_mm_mispred),
        .fu_free      (fu_free),
        .packet_out   (final_packet)
    );

    // mul wants the low word, the mulh variants the high word
    always_comb begin
        mult_result.valid = final_packet.valid;
        mult_result.dest  = final_packet.dest;
        mult_result.bm    = final_packet.bm;
        if (final_packet.func == m_mul) begin
            mult_result.result = final_packet.sum[xlen-1:0];
        end else begin
            mult_result.result = final_packet.sum[2*xlen-1:xlen];
        end
    end

    assign cdb_valid = final_packet.valid;

endmodule

//--- source/mult_operand_prep.sv
module mult_operand_prep import mult_pkg::*; (
    input  mult_packet_t       mult_packet_in,
    input  b_mask_t            b_mm_resolve,
    input  logic               b_mm_mispred,
    output mult_stage_packet_t stage_packet
);

    mult_stage_packet_t prepared;

    always_comb begin
        prepared        = nop_stage_packet;
        prepared.valid  = mult_packet_in.valid;
        prepared.sum    = '0;
        prepared.dest   = mult_packet_in.dest;
        prepared.bm     = mult_packet_in.bm;
        prepared.func   = mult_packet_in.func;

        // src1 is signed unless the op is mulhu
        case (mult_packet_in.func)
            m_mul, m_mulh, m_mulhsu: begin
                prepared.mcand = {{xlen{mult_packet_in.src1[xlen-1]}}, mult_packet_in.src1};
            end
            default: begin
                prepared.mcand = {{xlen{1'b0}}, mult_packet_in.src1};
            end
        endcase

        // src2 is signed only for mul and mulh
        case (mult_packet_in.func)
            m_mul, m_mulh: begin
                prepared.mplier = {{xlen{mult_packet_in.src2[xlen-1]}}, mult_packet_in.src2};
            end
            default: begin
                prepared.mplier = {{xlen{1'b0}}, mult_packet_in.src2};
            end
        endcase
    end

    // a branch resolving this cycle also applies to the packet being issued
    assign stage_packet = resolve_stage_packet(prepared, b_mm_resolve, b_mm_mispred);

endmodule

//--- source/mult_pipeline.sv
module mult_pipeline import mult_pkg::*; (
    input  logic               clock,
    input  logic               reset,
    input  mult_stage_packet_t packet_in,
    input  logic               cdb_en,
    input  b_mask_t            b_mm_resolve,
    input  logic               b_mm_mispred,
    output logic               fu_free,
    output mult_stage_packet_t packet_out
);

    logic [mult_stages-1:0] load_enable;
    mult_stage_packet_t     stage_in  [mult_stages];
    mult_stage_packet_t     stage_out [mult_stages];

    // a stage moves when the one after it moves or it holds nothing,
    // the bus grant stands in after the last stage
    always_comb begin
        load_enable[mult_stages-1] = cdb_en | ~stage_out[mult_stages-1].valid;
        for (int i = mult_stages - 2; i >= 0; i--) begin
            load_enable[i] = load_enable[i+1] | ~stage_out[i].valid;
        end
    end

    genvar s;
    for (s = 0; s < mult_stages; s++) begin : g_stage
        if (s == 0) begin : g_first
            assign stage_in[s] = packet_in;
        end else begin : g_link
            assign stage_in[s] = stage_out[s-1];
        end

        mult_stage u_stage (
            .clock        (clock),
            .reset        (reset),
            .load_enable  (load_enable[s]),
            .packet_in    (stage_in[s]),
            .b_mm_resolve (b_mm_resolve),
            .b_mm_mispred (b_mm_mispred),
            .packet_out   (stage_out[s])
        );
    end

    assign fu_free    = load_enable[0];
    assign packet_out = stage_out[mult_stages-1];

endmodule

//--- source/mult_pkg.sv
package mult_pkg;

    // data path widths
    localparam int xlen          = 32;
    localparam int mult_stages   = 4;
    // multiplier bits retired by each stage, legal stage counts are 2, 4 and 8
    localparam int slice_width   = 2 * xlen / mult_stages;

    // out-of-order bookkeeping
    localparam int b_mask_width  = 4;
    localparam int phys_reg_bits = 6;

    typedef logic [b_mask_width-1:0]  b_mask_t;
    typedef logic [phys_reg_bits-1:0] phys_reg_t;

    typedef enum logic [1:0] {
        m_mul,
        m_mulh,
        m_mulhsu,
        m_mulhu
    } mult_func_t;

    // issued multiply as it leaves the issue stage
    typedef struct packed {
        logic             valid;
        mult_func_t       func;
        logic [xlen-1:0]  src1;
        logic [xlen-1:0]  src2;
        phys_reg_t        dest;
        b_mask_t          bm;
    } mult_packet_t;

    // state carried from one multiply stage to the next
    typedef struct packed {
        logic              valid;
        logic [2*xlen-1:0] sum;
        logic [2*xlen-1:0] mplier;
        logic [2*xlen-1:0] mcand;
        phys_reg_t         dest;
        b_mask_t           bm;
        mult_func_t        func;
    } mult_stage_packet_t;

    // offer to the common data bus
    typedef struct packed {
        logic             valid;
        logic [xlen-1:0]  result;
        phys_reg_t        dest;
        b_mask_t          bm;
    } cdb_packet_t;

    localparam mult_stage_packet_t nop_stage_packet = '0;

    // clear resolved branch bits, or kill the entry on a mispredict
    function automatic mult_stage_packet_t resolve_stage_packet(
        input mult_stage_packet_t packet,
        input b_mask_t            resolve,
        input logic               mispred
    );
        mult_stage_packet_t updated;
        updated = packet;
        if ((packet.bm & resolve) != '0) begin
            if (mispred) begin
                updated = nop_stage_packet;
            end else begin
                updated.bm = packet.bm & ~resolve;
            end
        end
        return updated;
    endfunction

endpackage

//--- source/mult_stage.sv
module mult_stage import mult_pkg::*; (
    input  logic               clock,
    input  logic               reset,
    input  logic               load_enable,
    input  mult_stage_packet_t packet_in,
    input  b_mask_t            b_mm_resolve,
    input  logic               b_mm_mispred,
    output mult_stage_packet_t packet_out
);

    mult_stage_packet_t packet_q;
    mult_stage_packet_t stepped;
    logic [2*xlen-1:0]  slice;
    logic [2*xlen-1:0]  partial;

    // low multiplier slice times the already shifted multiplicand
    assign slice   = {{(2*xlen-slice_width){1'b0}}, packet_q.mplier[slice_width-1:0]};
    assign partial = slice * packet_q.mcand;

    always_comb begin
        stepped        = packet_q;
        stepped.sum    = packet_q.sum + partial;
        stepped.mplier = packet_q.mplier >> slice_width;
        stepped.mcand  = packet_q.mcand << slice_width;
    end

    // squash or mask update seen by the next stage and the bus in the same cycle
    assign packet_out = resolve_stage_packet(stepped, b_mm_resolve, b_mm_mispred);

    always_ff @(posedge clock) begin
        if (reset) begin
            packet_q <= nop_stage_packet;
        end else if (load_enable) begin
            packet_q <= packet_in;
        end else begin
            // held entry still has to track branch resolution
            packet_q <= resolve_stage_packet(packet_q, b_mm_resolve, b_mm_mispred);
        end
    end

endmodule
